/* src/spi_tx_pkg.sv */
// shared types and defaults for the SPI transmitter
// FIFO depth must be a power of two and at least 2
// the status word needs a data width of at least 3 bits

package spi_tx_pkg;

    // transfer states of the serializer FSM
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        READ_EN  = 3'd1,
        LOAD     = 3'd2,
        SHIFT    = 3'd3,
        COMPLETE = 3'd4
    } spi_state_t;

    // Wishbone register map, data is write-only and status is read-only
    typedef enum logic {
        REG_DATA   = 1'b0,
        REG_STATUS = 1'b1
    } wb_reg_t;

    localparam int DEFAULT_DATA_WIDTH = 8;
    localparam int DEFAULT_FIFO_DEPTH = 8;

    // bit positions inside the status word
    localparam int STATUS_EMPTY_BIT = 0;
    localparam int STATUS_FULL_BIT  = 1;
    localparam int STATUS_BUSY_BIT  = 2;

endpackage

/* src/wb_tx_port.sv */
// Wishbone classic slave in front of the transmit FIFO
// writes to a full FIFO are held off with wait states, never dropped
// wb_rdata is only meaningful in the cycle that carries wb_ack

`timescale 1ns/1ps

module wb_tx_port #(
    parameter int DATA_WIDTH = spi_tx_pkg::DEFAULT_DATA_WIDTH
) (
    input                         clk,
    input                         rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic                  wb_adr,
    input  logic [DATA_WIDTH-1:0] wb_wdata,
    output logic [DATA_WIDTH-1:0] wb_rdata,
    output logic                  wb_ack,
    input  logic                  full,
    input  logic                  empty,
    input  logic                  idle,
    output logic                  push,
    output logic [DATA_WIDTH-1:0] push_data
);

    spi_tx_pkg::wb_reg_t  reg_sel;
    logic                  cyc_active;
    logic                  data_write;
    logic                  ack_next;
    logic [DATA_WIDTH-1:0] status_word;

    assign reg_sel    = spi_tx_pkg::wb_reg_t'(wb_adr);
    // a cycle that was already acknowledged must not be answered twice
    assign cyc_active = wb_cyc && wb_stb && !wb_ack;
    assign data_write = wb_we && (reg_sel == spi_tx_pkg::REG_DATA);

    // a data write stalls here while the FIFO is full, everything else answers at once
    assign ack_next  = cyc_active && !(data_write && full);
    // the word enters the FIFO on the same edge that raises wb_ack
    assign push      = ack_next && data_write;
    assign push_data = wb_wdata;

    always_comb begin
        status_word = '0;
        status_word[spi_tx_pkg::STATUS_EMPTY_BIT] = empty;
        status_word[spi_tx_pkg::STATUS_FULL_BIT]  = full;
        // busy means the serializer has left IDLE
        status_word[spi_tx_pkg::STATUS_BUSY_BIT]  = !idle;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= ack_next;
        end
    end

    // the status snapshot is taken on the acknowledging edge
    always_ff @(posedge clk) begin
        if (ack_next && !wb_we) begin
            if (reg_sel == spi_tx_pkg::REG_STATUS) begin
                wb_rdata <= status_word;
            end else begin
                wb_rdata <= '0;
            end
        end
    end

endmodule

/* src/tx_fifo.sv */
// synchronous FIFO with a registered read port
// pop_data is valid on the edge after pop, not in the same cycle
// FIFO_DEPTH must be a power of two and at least 2

`timescale 1ns/1ps

module tx_fifo #(
    parameter int DATA_WIDTH = spi_tx_pkg::DEFAULT_DATA_WIDTH,
    parameter int FIFO_DEPTH = spi_tx_pkg::DEFAULT_FIFO_DEPTH
) (
    input                         clk,
    input                         rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] push_data,
    output logic [DATA_WIDTH-1:0] pop_data,
    output logic                  full,
    output logic                  empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    // one extra bit on each pointer tells a wrapped writer from an equal one
    logic [ADDR_W:0]       wr_ptr;
    logic [ADDR_W:0]       rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // requests against the flags are silently ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage and the read register
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

/* src/spi_serializer.sv */
// SPI mode 0 style transmitter, MSB first, transmit only
// sclk runs at clk/4 and its phase depends on the free-running divider,
// so a word takes one cycle more or less from word to word
// done pulses for one cycle at the end of every word

`timescale 1ns/1ps

module spi_serializer #(
    parameter int DATA_WIDTH = spi_tx_pkg::DEFAULT_DATA_WIDTH
) (
    input                         clk,
    input                         rst,
    input  logic                  empty,
    output logic                  pop,
    input  logic [DATA_WIDTH-1:0] pop_data,
    output logic                  spi_sclk,
    output logic                  spi_mosi,
    output logic                  spi_cs_n,
    output logic                  done,
    output logic                  idle
);

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    spi_tx_pkg::spi_state_t state;
    spi_tx_pkg::spi_state_t next_state;

    logic                  clk_div;
    logic                  sclk_enable;
    logic                  sclk_tick;
    logic                  sclk_fall;
    logic [CNT_W-1:0]      bit_counter;
    logic [DATA_WIDTH-1:0] shift_reg;

    // the FIFO is read in READ_EN and its data lands in LOAD
    assign pop  = (state == spi_tx_pkg::READ_EN);
    assign idle = (state == spi_tx_pkg::IDLE);

    // sclk only moves in SHIFT and stops once every bit has left
    assign sclk_enable = (state == spi_tx_pkg::SHIFT) && (bit_counter != '0);
    // toggle on the falling edge of the divider
    assign sclk_tick   = sclk_enable && clk_div;
    // a tick while sclk is high is the falling edge seen by the receiver
    assign sclk_fall   = sclk_tick && spi_sclk;

    // the line idles low whenever chip select is inactive
    assign spi_mosi = !spi_cs_n && shift_reg[DATA_WIDTH-1];

    always_comb begin
        next_state = state;
        case (state)
            spi_tx_pkg::IDLE: begin
                if (!empty) begin
                    next_state = spi_tx_pkg::READ_EN;
                end
            end
            spi_tx_pkg::READ_EN: begin
                next_state = spi_tx_pkg::LOAD;
            end
            spi_tx_pkg::LOAD: begin
                next_state = spi_tx_pkg::SHIFT;
            end
            spi_tx_pkg::SHIFT: begin
                // last bit has been held for a full sclk high phase
                if ((bit_counter == '0) && !spi_sclk) begin
                    next_state = spi_tx_pkg::COMPLETE;
                end
            end
            spi_tx_pkg::COMPLETE: begin
                next_state = spi_tx_pkg::IDLE;
            end
            default: begin
                next_state = spi_tx_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= spi_tx_pkg::IDLE;
            clk_div     <= 1'b0;
            spi_sclk    <= 1'b0;
            spi_cs_n    <= 1'b1;
            bit_counter <= '0;
            done        <= 1'b0;
        end else begin
            state   <= next_state;
            // free-running divide by two, sclk halves it again
            clk_div <= !clk_div;
            done    <= (state == spi_tx_pkg::COMPLETE);

            if (sclk_tick) begin
                spi_sclk <= !spi_sclk;
            end

            if (state == spi_tx_pkg::LOAD) begin
                spi_cs_n    <= 1'b0;
                bit_counter <= CNT_W'(DATA_WIDTH);
            end else if (state == spi_tx_pkg::COMPLETE) begin
                spi_cs_n <= 1'b1;
            end else if (sclk_fall) begin
                bit_counter <= bit_counter - 1'b1;
            end
        end
    end

    // shift left on every sclk fall so the next bit shows on mosi
    always_ff @(posedge clk) begin
        if (state == spi_tx_pkg::LOAD) begin
            shift_reg <= pop_data;
        end else if (sclk_fall) begin
            shift_reg <= {shift_reg[DATA_WIDTH-2:0], 1'b0};
        end
    end

endmodule

/* src/spi_tx_top.sv */
// SPI transmitter with a Wishbone classic host port
// words written to the data register are sent in write order on mosi
// the only back-pressure is wait states on wb_ack while the FIFO is full

`timescale 1ns/1ps

module spi_tx_top #(
    parameter int DATA_WIDTH = spi_tx_pkg::DEFAULT_DATA_WIDTH,
    parameter int FIFO_DEPTH = spi_tx_pkg::DEFAULT_FIFO_DEPTH
) (
    input                         clk,
    input                         rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic                  wb_adr,
    input  logic [DATA_WIDTH-1:0] wb_wdata,
    output logic [DATA_WIDTH-1:0] wb_rdata,
    output logic                  wb_ack,
    output logic                  spi_sclk,
    output logic                  spi_mosi,
    output logic                  spi_cs_n,
    output logic                  done
);

    logic                  push;
    logic [DATA_WIDTH-1:0] push_data;
    logic                  pop;
    logic [DATA_WIDTH-1:0] pop_data;
    logic                  full;
    logic                  empty;
    logic                  idle;

    // host side, turns bus writes into FIFO pushes
    wb_tx_port #(
        .DATA_WIDTH (DATA_WIDTH)
    ) port_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .full      (full),
        .empty     (empty),
        .idle      (idle),
        .push      (push),
        .push_data (push_data)
    );

    tx_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    // serial side, drains one word per cs_n window
    spi_serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) ser_i (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .pop      (pop),
        .pop_data (pop_data),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .done     (done),
        .idle     (idle)
    );

endmodule

/* tests/spi_tx_sva.sv */
// protocol checker bound to the SPI transmitter top level
// every property is sampled on the rising clock edge and disabled during reset
// assert_failures counts failed properties for the testbench summary

`timescale 1ns/1ps

module spi_tx_sva (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic spi_sclk,
    input logic spi_mosi,
    input logic spi_cs_n,
    input logic done
);

    int assert_failures = 0;

    // done marks the end of one word and never stretches
    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
    else begin
        assert_failures = assert_failures + 1;
        $error("done stayed high for two cycles");
    end

    // the acknowledge answers a strobe that was present on the previous edge
    ack_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else begin
        assert_failures = assert_failures + 1;
        $error("wb_ack rose without an active strobe");
    end

    // the serial lines are quiet between words
    quiet_while_deselected: assert property (@(posedge clk) disable iff (rst)
        (spi_cs_n && $past(spi_cs_n)) |-> ($stable(spi_sclk) && $stable(spi_mosi)))
    else begin
        assert_failures = assert_failures + 1;
        $error("sclk or mosi moved while cs_n was high");
    end

    // the receiver samples on the rise, so mosi must hold through the high phase
    mosi_stable_sclk_high: assert property (@(posedge clk) disable iff (rst)
        (spi_sclk && $past(spi_sclk)) |-> $stable(spi_mosi))
    else begin
        assert_failures = assert_failures + 1;
        $error("mosi changed while sclk was high");
    end

endmodule

bind spi_tx_top spi_tx_sva sva_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_cs_n (spi_cs_n),
    .done     (done)
);

/* tests/spi_tx_tb.sv */
// testbench for the SPI transmitter with a Wishbone classic host
// inputs change on the falling clock edge, outputs are sampled there too
// the receiver model expects MSB first with sampling on each sclk rise

`timescale 1ns/1ps

module spi_tx_tb;

    localparam int DATA_WIDTH     = spi_tx_pkg::DEFAULT_DATA_WIDTH;
    localparam int FIFO_DEPTH     = spi_tx_pkg::DEFAULT_FIFO_DEPTH;
    localparam int NUM_WORDS      = 1 + FIFO_DEPTH + 4;
    localparam int TIMEOUT_CYCLES = NUM_WORDS * (4 * DATA_WIDTH + 20) + 16 + 200;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic                  wb_adr;
    logic [DATA_WIDTH-1:0] wb_wdata;
    logic [DATA_WIDTH-1:0] wb_rdata;
    logic                  wb_ack;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic                  spi_cs_n;
    logic                  done;

    logic [DATA_WIDTH-1:0] exp_q[$];
    logic [DATA_WIDTH-1:0] rx_word;
    logic [DATA_WIDTH-1:0] status;
    logic [31:0]           lcg_state = 32'h9a500a27;
    logic                  sclk_prev;
    int                    rx_bits;
    int                    done_count = 0;
    int                    error_count = 0;
    string                 cur_test = "reset_values";

    spi_tx_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            error_count++;
        end
    endtask

    // one classic cycle, stb is dropped on the falling edge that sees the ack
    task automatic wb_cycle(input logic we, input spi_tx_pkg::wb_reg_t adr,
                            input logic [DATA_WIDTH-1:0] wdata,
                            output logic [DATA_WIDTH-1:0] rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata  = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input spi_tx_pkg::wb_reg_t adr, input logic [DATA_WIDTH-1:0] data);
        logic [DATA_WIDTH-1:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input spi_tx_pkg::wb_reg_t adr, output logic [DATA_WIDTH-1:0] data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    // the expected word is queued before the bus write can complete
    task automatic send_word();
        logic [DATA_WIDTH-1:0] word;
        lcg_state = lcg_next(lcg_state);
        word = lcg_state[31 -: DATA_WIDTH];
        exp_q.push_back(word);
        wb_write(spi_tx_pkg::REG_DATA, word);
    endtask

    task automatic wait_for_words(input int n);
        while (done_count < n) @(negedge clk);
    endtask

    // receiver model, a rise of sclk between two falling clock edges is a sample
    always @(negedge clk) begin
        if (rst) begin
            rx_bits   = 0;
            sclk_prev = 1'b0;
        end else begin
            if (!spi_cs_n && spi_sclk && !sclk_prev) begin
                rx_word = {rx_word[DATA_WIDTH-2:0], spi_mosi};
                rx_bits++;
            end
            sclk_prev = spi_sclk;
            if (done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("%s: a done pulse arrived with no word outstanding", cur_test);
                    error_count++;
                end else begin
                    check_value({cur_test, "_word"}, 32'(exp_q.pop_front()), 32'(rx_word));
                end
                check_value({cur_test, "_bits"}, 32'(DATA_WIDTH), 32'(rx_bits));
                rx_bits = 0;
            end
        end
    end

    // limit derived from the longest possible word time
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d words done", TIMEOUT_CYCLES,
                 done_count);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 1'b0;
        wb_wdata = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_value("reset_cs_n", 32'd1, 32'(spi_cs_n));
        check_value("reset_lines", 32'd0, 32'({spi_sclk, spi_mosi, done, wb_ack}));
        wb_read(spi_tx_pkg::REG_STATUS, status);
        check_value("reset_status", 32'(1) << spi_tx_pkg::STATUS_EMPTY_BIT, 32'(status));

        cur_test = "single_word";
        send_word();
        wait_for_words(1);

        // the first burst word leaves at once, the next FIFO_DEPTH fill the FIFO
        cur_test = "burst";
        repeat (FIFO_DEPTH + 1) send_word();
        wb_read(spi_tx_pkg::REG_STATUS, status);
        check_value("burst_full", 32'd1, 32'(status[spi_tx_pkg::STATUS_FULL_BIT]));
        check_value("burst_busy", 32'd1, 32'(status[spi_tx_pkg::STATUS_BUSY_BIT]));
        repeat (3) send_word();
        wait_for_words(NUM_WORDS);

        cur_test = "drain";
        repeat (2) @(negedge clk);
        wb_read(spi_tx_pkg::REG_STATUS, status);
        check_value("drain_status", 32'(1) << spi_tx_pkg::STATUS_EMPTY_BIT, 32'(status));
        check_value("drain_queue", 32'd0, 32'(exp_q.size()));

        $display("errors: value checks %0d, protocol assertions %0d", error_count,
                 dut_i.sva_i.assert_failures);
        if (error_count == 0 && dut_i.sva_i.assert_failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
src/spi_tx_pkg.sv
src/wb_tx_port.sv
src/tx_fifo.sv
src/spi_serializer.sv
src/spi_tx_top.sv
tests/spi_tx_sva.sv
tests/spi_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the SPI transmitter testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module spi_tx_tb \
    -Mdir obj_dir -o spi_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/spi_tx_sim +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi

exit 0
